// File: Bender.yml
package:
  name: hazard_unit

sources:
  - files:
      - src/isaPkg.sv
      - src/hazardPkg.sv
      - src/instrDecode.sv
      - src/stageShift.sv
      - src/hazardCheck.sv
      - src/stallControl.sv
      - src/hazardUnit.sv
  - target: simulation
    files:
      - sim/hazardUnit_assert.sv
      - sim/hazardUnitTb.sv

// File: files.f
src/isaPkg.sv
src/hazardPkg.sv
src/instrDecode.sv
src/stageShift.sv
src/hazardCheck.sv
src/stallControl.sv
src/hazardUnit.sv
sim/hazardUnit_assert.sv
sim/hazardUnitTb.sv

// File: sim/hazardUnitTb.sv
`timescale 1ns/10ps
`default_nettype none

module hazardUnitTb;
    import isaPkg::*;
    import hazardPkg::*;

    localparam int      resetCycles  = 16;
    localparam int      resetTimeout = 8;         // Cycles for outputs to clear after reset
    localparam int      sampleDelay  = 8;         // ns after the falling edge, before the rise
    localparam opcode_t opAddi       = 5'b00001;  // Immediate ALU form, reads rs only

    // One stimulus row with its worked-out response
    typedef struct packed {
        logic [2:0] group;
        word_t      instr;
        word_t      imm;
        word_t      reg1Data;
        regIdx_t    rd;
        logic       regWrite;
        logic       memEnable;
        logic       branchTaken;
        logic       expNop;
        logic       expPcStall;
        fwdSel_t    expFwd;
    } row_t;

    logic    clk;
    logic    rstN;
    word_t   instr;
    word_t   imm;
    word_t   reg1Data;
    regIdx_t rd;
    logic    regWrite;
    logic    memEnable;
    logic    branchTaken;
    logic    nop;
    logic    pcStall;
    fwdSel_t forwards;

    row_t  stimRows [$];
    int    checks;
    int    errors;
    bit    resetOk;
    string groupName [5] = '{"register hazard by distance", "forwarding selects",
                             "memory hazard", "jump bubble", "branch squash"};

    hazardUnit #(
        .trackDepth (4)
    ) dut (
        .clk         (clk),
        .rstN        (rstN),
        .instr       (instr),
        .imm         (imm),
        .reg1Data    (reg1Data),
        .rd          (rd),
        .regWrite    (regWrite),
        .memEnable   (memEnable),
        .branchTaken (branchTaken),
        .nop         (nop),
        .pcStall     (pcStall),
        .forwards    (forwards)
    );

    always #10 clk = ~clk;   // 20 ns period

    // Opcode, rs, rt, low five bits zero
    function automatic word_t encode(input opcode_t op, input regIdx_t rs, input regIdx_t rt);
        return {op, rs, rt, 5'b00000};
    endfunction

    task automatic addRow(input int grp, input word_t ins, input word_t immVal,
                          input word_t baseVal, input regIdx_t rdVal, input logic wr,
                          input logic mem, input logic br, input logic nopExp,
                          input logic pcExp, input fwdSel_t fwdExp);
        row_t r;
        r = '{grp, ins, immVal, baseVal, rdVal, wr, mem, br, nopExp, pcExp, fwdExp};
        stimRows.push_back(r);
    endtask

    // grp, instr, imm, reg1Data, rd, regWrite, memEnable, branchTaken, nop, pcStall, forwards
    task automatic buildTable();
        addRow(0, encode(opAddi, 0, 0), 16'h0, 16'h0, 3, 1, 0, 0, 0, 0, 6'b000000); // Write r3
        addRow(0, encode(opAddi, 3, 0), 16'h0, 16'h0, 0, 0, 0, 0, 1, 1, 6'b100000); // r3 in ID
        addRow(0, encode(opAddi, 3, 0), 16'h0, 16'h0, 0, 0, 0, 0, 1, 1, 6'b000010); // EX
        addRow(0, encode(opAddi, 3, 0), 16'h0, 16'h0, 0, 0, 0, 0, 1, 1, 6'b000001); // MEM
        addRow(0, encode(opAddi, 3, 0), 16'h0, 16'h0, 0, 0, 0, 0, 1, 1, 6'b000000); // WB
        addRow(0, encode(opAddi, 3, 0), 16'h0, 16'h0, 0, 0, 0, 0, 0, 0, 6'b000000); // Gone
        addRow(0, encode(opAddi, 0, 0), 16'h0, 16'h0, 3, 1, 0, 0, 0, 0, 6'b000000);
        addRow(0, encode(opJr, 0, 3),   16'h0, 16'h0, 0, 0, 0, 0, 0, 1, 6'b001000); // rt unused
        addRow(0, encode(opAddi, 0, 0), 16'h0, 16'h0, 0, 0, 0, 0, 0, 0, 6'b000000);
        addRow(1, encode(opAddi, 0, 0), 16'h0, 16'h0, 4, 1, 0, 0, 0, 0, 6'b000000); // Write r4
        addRow(1, encode(opRAlu, 4, 4), 16'h0, 16'h0, 0, 0, 0, 0, 1, 1, 6'b101000);
        addRow(1, encode(opLd, 0, 0), 16'h0040, 16'h0100, 5, 1, 1, 0, 0, 0, 6'b000000);
        addRow(1, encode(opRAlu, 0, 5), 16'h0, 16'h0, 0, 0, 0, 0, 1, 1, 6'b001100); // Load in ID
        addRow(1, encode(opAddi, 5, 0), 16'h0, 16'h0, 0, 0, 0, 0, 1, 1, 6'b000000); // EX is load
        addRow(1, encode(opAddi, 5, 0), 16'h0, 16'h0, 0, 0, 0, 0, 1, 1, 6'b000001);
        addRow(1, encode(opAddi, 0, 0), 16'h0, 16'h0, 0, 0, 0, 0, 0, 0, 6'b000000);
        addRow(1, encode(opLd, 0, 0), 16'h0040, 16'h0100, 6, 1, 1, 0, 0, 0, 6'b000000);
        addRow(1, encode(opAddi, 6, 0), 16'h0, 16'h0, 0, 0, 0, 0, 1, 1, 6'b110000); // Load on rs
        addRow(2, encode(opSt, 0, 0), 16'h0010, 16'h0200, 0, 0, 1, 0, 0, 0, 6'b000000);
        addRow(2, encode(opLd, 0, 0), 16'h0008, 16'h0208, 0, 0, 1, 0, 1, 1, 6'b000000);
        addRow(2, encode(opLd, 0, 0), 16'h0000, 16'h0300, 0, 0, 1, 0, 0, 0, 6'b000000);
        addRow(2, encode(opAddi, 0, 0), 16'h0010, 16'h0200, 0, 0, 0, 0, 0, 0, 6'b000000);
        addRow(2, encode(opSt, 0, 0), 16'h0000, 16'h0210, 0, 0, 1, 0, 1, 1, 6'b000000); // WB hit
        addRow(2, encode(opLd, 0, 0), 16'h0000, 16'h0210, 0, 0, 1, 0, 0, 0, 6'b000000);
        addRow(3, encode(opJ, 0, 0),    16'h0, 16'h0, 0, 0, 0, 0, 0, 1, 6'b000000); // New J
        addRow(3, encode(opJ, 0, 0),    16'h0, 16'h0, 0, 0, 0, 0, 0, 0, 6'b000000); // Held
        addRow(3, encode(opJ, 0, 0),    16'h0, 16'h0, 0, 0, 0, 0, 0, 0, 6'b000000);
        addRow(3, encode(opAddi, 0, 0), 16'h0, 16'h0, 0, 0, 0, 0, 0, 0, 6'b000000);
        addRow(3, encode(opJal, 0, 0),  16'h0, 16'h0, 0, 0, 0, 0, 0, 1, 6'b000000);
        addRow(3, encode(opAddi, 7, 0), 16'h0, 16'h0, 0, 0, 0, 0, 1, 0, 6'b100000); // PC gated
        addRow(3, encode(opAddi, 7, 0), 16'h0, 16'h0, 0, 0, 0, 0, 1, 1, 6'b000010);
        addRow(4, encode(opAddi, 0, 0), 16'h0, 16'h0, 2, 1, 0, 0, 0, 0, 6'b000000); // Write r2
        addRow(4, encode(opAddi, 0, 0), 16'h0, 16'h0, 0, 0, 0, 1, 0, 0, 6'b000000); // Taken
        addRow(4, encode(opAddi, 2, 0), 16'h0, 16'h0, 0, 0, 0, 0, 0, 0, 6'b000000);
        addRow(4, encode(opAddi, 0, 0), 16'h0, 16'h0, 2, 1, 0, 0, 0, 0, 6'b000000);
        addRow(4, encode(opAddi, 2, 0), 16'h0, 16'h0, 0, 0, 0, 1, 0, 0, 6'b000000); // Masked
        addRow(4, encode(opAddi, 2, 0), 16'h0, 16'h0, 0, 0, 0, 0, 0, 0, 6'b000000);
    endtask

    task automatic applyReset(output bit ok);
        int waited;
        waited = 0;
        for (int c = 0; c < resetCycles; c++) begin
            @(posedge clk);
        end
        @(negedge clk);
        rstN = 1'b1;
        // Outputs must settle to idle within a few cycles
        while ((nop !== 1'b0 || pcStall !== 1'b0 || forwards !== '0) && waited < resetTimeout) begin
            @(negedge clk);
            waited++;
        end
        ok = (nop === 1'b0 && pcStall === 1'b0 && forwards === '0);
    endtask

    task automatic applyRow(input row_t r, input int idx, output int rowErr);
        rowErr = 0;
        @(negedge clk);                 // Drive mid-cycle
        instr       = r.instr;
        imm         = r.imm;
        reg1Data    = r.reg1Data;
        rd          = r.rd;
        regWrite    = r.regWrite;
        memEnable   = r.memEnable;
        branchTaken = r.branchTaken;
        #sampleDelay;                   // Just before the next rising edge
        checks += 3;
        if (nop !== r.expNop) begin
            $display("Mismatch at %0t: row %0d nop expected %b got %b",
                     $time, idx, r.expNop, nop);
            rowErr++;
        end
        if (pcStall !== r.expPcStall) begin
            $display("Mismatch at %0t: row %0d pcStall expected %b got %b",
                     $time, idx, r.expPcStall, pcStall);
            rowErr++;
        end
        if (forwards !== r.expFwd) begin
            $display("Mismatch at %0t: row %0d forwards expected %b got %b",
                     $time, idx, r.expFwd, forwards);
            rowErr++;
        end
    endtask

    task automatic runTable();
        int groupErr;
        int groupRows;
        int rowErr;
        groupErr  = 0;
        groupRows = 0;
        for (int i = 0; i < stimRows.size(); i++) begin
            applyRow(stimRows[i], i, rowErr);
            groupErr += rowErr;
            errors   += rowErr;
            groupRows++;
            // Group ends at the last row or where the next group starts
            if (i == stimRows.size() - 1 || stimRows[i+1].group != stimRows[i].group) begin
                $display("Test %0d, %s: %0d rows, %0d errors",
                         stimRows[i].group + 1, groupName[stimRows[i].group],
                         groupRows, groupErr);
                groupErr  = 0;
                groupRows = 0;
            end
        end
    endtask

    initial begin
        clk         = 1'b0;
        rstN        = 1'b0;
        instr       = encode(opAddi, 0, 0);   // Harmless filler during reset
        imm         = '0;
        reg1Data    = '0;
        rd          = '0;
        regWrite    = 1'b0;
        memEnable   = 1'b0;
        branchTaken = 1'b0;
        checks      = 0;
        errors      = 0;
        buildTable();
        applyReset(resetOk);
        if (!resetOk) begin
            $display("Timeout: DUT outputs did not go idle after reset");
            $display("SIMULATION FAILED");
        end else begin
            runTable();
            errors += dut.u_assert.failCount;   // Bound property failures
            $display("Checks: %0d, errors: %0d", checks, errors);
            if (errors == 0) begin
                $display("SIMULATION PASSED");
            end else begin
                $display("SIMULATION FAILED");
            end
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/hazardUnit_assert.sv
`timescale 1ns/10ps
`default_nettype none

module hazardUnitAssert (
    input logic               clk,
    input logic               rstN,
    input isaPkg::word_t      instr,
    input logic               branchTaken,
    input logic               nop,
    input logic               pcStall,
    input hazardPkg::fwdSel_t forwards
);
    import isaPkg::*;

    logic isJump;
    int   failCount = 0;   // Failed properties so far

    assign isJump = (instr[15:13] == opJ[4:2]);   // J, JR, JAL and JALR share 001xx

    // Shadow stages are cleared, nothing may look like a hazard
    resetQuiet: assert property (@(posedge clk)
        !rstN ##1 !rstN |-> !nop && forwards == '0)
        else begin
            $error("nop or forwards active while reset is held");
            failCount++;
        end

    // A held jump gets a single PC stall
    oneJumpStall: assert property (@(posedge clk) disable iff (!rstN)
        (pcStall && isJump && !nop) ##1 ($stable(instr) && !nop) |-> !pcStall)
        else begin
            $error("pcStall raised twice for the same jump");
            failCount++;
        end

    // Squashed ID entry never feeds EX
    squashNoFwd: assert property (@(posedge clk) disable iff (!rstN)
        branchTaken |-> !forwards.exToExRs)
        else begin
            $error("exToExRs set during a taken branch");
            failCount++;
        end

endmodule

bind hazardUnit hazardUnitAssert u_assert (
    .clk         (clk),
    .rstN        (rstN),
    .instr       (instr),
    .branchTaken (branchTaken),
    .nop         (nop),
    .pcStall     (pcStall),
    .forwards    (forwards)
);

`default_nettype wire

// File: src/hazardCheck.sv
`timescale 1ns/10ps
`default_nettype none

module hazardCheck #(
    parameter int trackDepth = 4
) (
    input  hazardPkg::issue_t     issue,
    input  logic                  branchTaken,
    input  hazardPkg::regTrack_t  regStage [trackDepth],
    input  logic [trackDepth-1:0] regValid,
    input  hazardPkg::memTrack_t  memStage [trackDepth],
    input  logic [trackDepth-1:0] memValid,
    output logic                  regHazard,
    output logic                  memHazard,
    output hazardPkg::fwdSel_t    forwards
);

    localparam int idStage     = 0;
    localparam int exStage     = 1;
    localparam int memStageIdx = 2;

    logic [trackDepth-1:0] branchMask;
    logic [trackDepth-1:0] regLive;
    logic [trackDepth-1:0] memLive;
    logic [trackDepth-1:0] rsMatch;
    logic [trackDepth-1:0] rtMatch;
    logic [trackDepth-1:0] addrMatch;

    // ID entry is being squashed, so it counts for nothing this cycle
    assign branchMask = {{(trackDepth-1){1'b0}}, branchTaken};
    assign regLive    = regValid & ~branchMask;
    assign memLive    = memValid & ~branchMask;

    // Per-stage compares
    always_comb begin
        for (int i = 0; i < trackDepth; i++) begin
            rsMatch[i]   = regLive[i] && (regStage[i] == issue.rs);
            rtMatch[i]   = regLive[i] && (regStage[i] == issue.rt);
            addrMatch[i] = memLive[i] && (memStage[i] == issue.memAddr);
        end
    end

    // Register RAW, rt of JR/JALR is not a real operand
    assign regHazard = (issue.usesRs & (|rsMatch))
                     | (issue.usesRt & ~issue.isJumpReg & (|rtMatch));

    // Memory RAW on the same effective address
    assign memHazard = issue.memEnable & (|addrMatch);

    // Forwarding selects travel with the instruction into EX
    always_comb begin
        forwards.exToExRs  = rsMatch[idStage];
        forwards.exToExRt  = rtMatch[idStage];
        forwards.memToExRs = rsMatch[idStage] & memLive[idStage];  // Producer is a load in ID
        forwards.memToExRt = rtMatch[idStage] & memLive[idStage];
        forwards.exToIdRs  = rsMatch[exStage] & ~memValid[exStage];  // EX value not ready for memory ops
        forwards.memToIdRs = rsMatch[memStageIdx];
    end

endmodule

`default_nettype wire

// File: src/hazardPkg.sv
`default_nettype none

package hazardPkg;

    // Everything the hazard logic needs about the instruction in decode
    typedef struct packed {
        isaPkg::regIdx_t rs;         // First source
        isaPkg::regIdx_t rt;         // Second source
        logic            usesRs;
        logic            usesRt;
        isaPkg::regIdx_t dest;       // Already r7 for link forms
        logic            writesReg;
        logic            memEnable;  // Load or store
        isaPkg::word_t   memAddr;    // reg1Data plus imm
        logic            isJump;     // Any of J, JR, JAL, JALR
        logic            isJumpReg;  // JR and JALR only
    } issue_t;

    // Payload carried by the register shadow pipeline
    typedef isaPkg::regIdx_t regTrack_t;

    // Payload carried by the memory shadow pipeline
    typedef isaPkg::word_t memTrack_t;

    // Forwarding selects, MSB first as the datapath expects them
    typedef struct packed {
        logic exToExRs;              // ID result into EX, rs operand
        logic memToExRs;             // ID load result into EX, rs operand
        logic exToExRt;
        logic memToExRt;
        logic exToIdRs;              // EX result back to decode for JR/JALR
        logic memToIdRs;             // MEM result back to decode
    } fwdSel_t;

endpackage

`default_nettype wire

// File: src/hazardUnit.sv
`timescale 1ns/10ps
`default_nettype none

module hazardUnit #(
    parameter int trackDepth = 4        // ID, EX, MEM, WB
) (
    input  logic               clk,
    input  logic               rstN,
    input  isaPkg::word_t      instr,
    input  isaPkg::word_t      imm,
    input  isaPkg::word_t      reg1Data,
    input  isaPkg::regIdx_t    rd,
    input  logic               regWrite,
    input  logic               memEnable,
    input  logic               branchTaken,
    output logic               nop,
    output logic               pcStall,
    output hazardPkg::fwdSel_t forwards
);
    import hazardPkg::*;

    issue_t                issue;
    regTrack_t             regStage [trackDepth];
    logic [trackDepth-1:0] regValid;
    memTrack_t             memStage [trackDepth];
    logic [trackDepth-1:0] memValid;
    logic                  regHazard;
    logic                  memHazard;
    logic                  bubble;

    instrDecode u_decode (
        .instr     (instr),
        .imm       (imm),
        .reg1Data  (reg1Data),
        .rd        (rd),
        .regWrite  (regWrite),
        .memEnable (memEnable),
        .issue     (issue)
    );

    // Destination registers of older instructions
    stageShift #(
        .trackDepth (trackDepth),
        .payload_t  (regTrack_t)
    ) regStages (
        .clk        (clk),
        .rstN       (rstN),
        .inData     (issue.dest),
        .inValid    (issue.writesReg),
        .bubble     (bubble),
        .squash     (branchTaken),
        .stageData  (regStage),
        .stageValid (regValid)
    );

    // Memory addresses of older instructions
    stageShift #(
        .trackDepth (trackDepth),
        .payload_t  (memTrack_t)
    ) memStages (
        .clk        (clk),
        .rstN       (rstN),
        .inData     (issue.memAddr),
        .inValid    (issue.memEnable),
        .bubble     (bubble),
        .squash     (branchTaken),
        .stageData  (memStage),
        .stageValid (memValid)
    );

    hazardCheck #(
        .trackDepth (trackDepth)
    ) u_check (
        .issue       (issue),
        .branchTaken (branchTaken),
        .regStage    (regStage),
        .regValid    (regValid),
        .memStage    (memStage),
        .memValid    (memValid),
        .regHazard   (regHazard),
        .memHazard   (memHazard),
        .forwards    (forwards)
    );

    stallControl u_stall (
        .clk       (clk),
        .rstN      (rstN),
        .instr     (instr),
        .isJump    (issue.isJump),
        .regHazard (regHazard),
        .memHazard (memHazard),
        .nop       (nop),
        .pcStall   (pcStall),
        .bubble    (bubble)
    );

endmodule

`default_nettype wire

// File: src/instrDecode.sv
`timescale 1ns/10ps
`default_nettype none

module instrDecode (
    input  isaPkg::word_t     instr,
    input  isaPkg::word_t     imm,
    input  isaPkg::word_t     reg1Data,
    input  isaPkg::regIdx_t   rd,
    input  logic              regWrite,
    input  logic              memEnable,
    output hazardPkg::issue_t issue
);
    import isaPkg::*;

    instrFields_t fields;
    opndUse_t     opndUse;
    logic         isLink;
    logic         isJump;
    logic         isJumpReg;

    assign fields = instrFields_t'(instr);

    // Opcode classification
    always_comb begin
        opndUse   = useRs;           // Most opcodes read rs only
        isJump    = 1'b0;
        isJumpReg = 1'b0;
        isLink    = 1'b0;
        case (fields.opcode) inside
            opJ: begin
                opndUse = useNone;
                isJump  = 1'b1;
            end
            opJal: begin
                opndUse = useNone;
                isJump  = 1'b1;
                isLink  = 1'b1;
            end
            opJr: begin
                isJump    = 1'b1;
                isJumpReg = 1'b1;
            end
            opJalr: begin
                isJump    = 1'b1;
                isJumpReg = 1'b1;
                isLink    = 1'b1;
            end
            [{opBranchMsb, 2'b00} : {opBranchMsb, 2'b11}]: opndUse = useRs;  // Compare rs only
            opLd:               opndUse = useRs;   // Base register
            opSt:               opndUse = useRsRt; // Base plus store data
            opRAlu, opRShift:   opndUse = useRsRt;
            default:            opndUse = useRs;
        endcase
    end

    // Issue record
    always_comb begin
        issue.rs        = fields.rs;
        issue.rt        = fields.rt;
        issue.usesRs    = (opndUse != useNone);
        issue.usesRt    = (opndUse == useRsRt);
        issue.dest      = isLink ? linkReg : rd;  // Link writes the return address
        issue.writesReg = regWrite | isLink;      // r7 is written even without regWrite
        issue.memEnable = memEnable;
        issue.memAddr   = reg1Data + imm;         // Effective address, carry dropped
        issue.isJump    = isJump;
        issue.isJumpReg = isJumpReg;
    end

endmodule

`default_nettype wire

// File: src/isaPkg.sv
`default_nettype none

package isaPkg;

    typedef logic [15:0] word_t;     // Instruction or data word
    typedef logic [2:0]  regIdx_t;   // Eight architectural registers
    typedef logic [4:0]  opcode_t;   // Top five bits of every instruction

    // Field view of an instruction word
    typedef struct packed {
        opcode_t     opcode;         // Bits 15 to 11
        regIdx_t     rs;             // Bits 10 to 8
        regIdx_t     rt;             // Bits 7 to 5
        logic [4:0]  funct;          // Low bits, immediate or function
    } instrFields_t;

    // Which source registers an instruction reads
    typedef enum logic [1:0] {
        useNone,                     // J and JAL read nothing
        useRs,                       // Immediate forms, loads, branches, JR, JALR
        useRsRt                      // R-format and stores read both
    } opndUse_t;

    // Jumps
    localparam opcode_t opJ    = 5'b00100;
    localparam opcode_t opJr   = 5'b00101;
    localparam opcode_t opJal  = 5'b00110;
    localparam opcode_t opJalr = 5'b00111;

    // Branch group is 011xx, low two bits pick the condition
    localparam logic [2:0] opBranchMsb = 3'b011;

    // Memory and register-register groups
    localparam opcode_t opSt     = 5'b10000;
    localparam opcode_t opLd     = 5'b10001;
    localparam opcode_t opRAlu   = 5'b11011;
    localparam opcode_t opRShift = 5'b11010;

    localparam regIdx_t linkReg = 3'd7;  // Return address register

endpackage

`default_nettype wire

// File: src/stageShift.sv
`timescale 1ns/10ps
`default_nettype none

module stageShift #(
    parameter int  trackDepth = 4,
    parameter type payload_t  = logic
) (
    input  logic                  clk,
    input  logic                  rstN,
    input  payload_t              inData,
    input  logic                  inValid,
    input  logic                  bubble,     // Decode instruction held back this cycle
    input  logic                  squash,     // Taken branch kills the ID entry
    output payload_t              stageData [trackDepth],
    output logic [trackDepth-1:0] stageValid
);

    // Payload shift, index 0 is ID
    always_ff @(posedge clk) begin
        stageData[0] <= inData;
        for (int i = 1; i < trackDepth; i++) begin
            stageData[i] <= stageData[i-1];
        end
    end

    // Valid bits move alongside the payload
    always_ff @(posedge clk) begin
        if (!rstN) begin
            stageValid <= '0;
        end else begin
            stageValid[0] <= inValid & ~bubble;        // Stalled instruction enters as a bubble
            stageValid[1] <= stageValid[0] & ~squash;  // ID to EX dies on a taken branch
            for (int i = 2; i < trackDepth; i++) begin
                stageValid[i] <= stageValid[i-1];
            end
        end
    end

endmodule

`default_nettype wire

// File: src/stallControl.sv
`timescale 1ns/10ps
`default_nettype none

module stallControl (
    input  logic          clk,
    input  logic          rstN,
    input  isaPkg::word_t instr,
    input  logic          isJump,
    input  logic          regHazard,
    input  logic          memHazard,
    output logic          nop,
    output logic          pcStall,
    output logic          bubble
);
    import isaPkg::*;

    word_t prevInstr;   // Instruction seen in decode last cycle
    logic  prevJump;    // Already stalled once for this jump
    logic  newInstr;
    logic  jumpStall;

    assign newInstr  = (instr != prevInstr);
    assign jumpStall = isJump & ~prevJump;   // One bubble per jump

    assign nop    = regHazard | memHazard;
    assign bubble = nop;                     // Held instruction must not be tracked

    // Hazards and fresh jumps freeze the PC, but never twice for one jump
    assign pcStall = (nop | (jumpStall & newInstr)) & ~prevJump;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            prevInstr <= '0;
            prevJump  <= 1'b0;
        end else begin
            prevInstr <= instr;
            prevJump  <= jumpStall & ~nop;   // Only counts once the jump could issue
        end
    end

endmodule

`default_nettype wire
